//--- rtl/harness_params.svh
`ifndef HARNESS_PARAMS_SVH
`define HARNESS_PARAMS_SVH

// Bus widths
`define HARNESS_ADDR_W 16
`define HARNESS_DATA_W 32
`define HARNESS_BE_W (`HARNESS_DATA_W / 8)

// Memory sizes in words
`define HARNESS_ROM_WORDS 256
`define HARNESS_RAM_WORDS 256

// Cycles the debug request stays blocked after reset
`define HARNESS_DBG_DELAY 20

// Upper half of each boot ROM word
`define HARNESS_ROM_TAG 16'hB007

`endif

//--- rtl/harness_bus_pkg.sv
`include "harness_params.svh"

package harness_bus_pkg;

  // --------------------------------------------------------------------------
  // Response status
  // --------------------------------------------------------------------------
  typedef enum logic {
    RESP_OKAY  = 1'b0,
    RESP_ERROR = 1'b1
  } resp_status_e;

  // --------------------------------------------------------------------------
  // Transfer payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [`HARNESS_ADDR_W-1:0] addr;
    logic                       we;
    logic [`HARNESS_BE_W-1:0]   be;
    logic [`HARNESS_DATA_W-1:0] wdata;
  } bus_req_t;

  // Read data is zero for writes and errors
  typedef struct packed {
    logic [`HARNESS_DATA_W-1:0] rdata;
    resp_status_e               status;
  } bus_resp_t;

endpackage

//--- rtl/harness_map_pkg.sv
`include "harness_params.svh"

package harness_map_pkg;

  typedef logic [`HARNESS_ADDR_W-1:0] addr_t;

  // Word index wide enough for the larger memory
  localparam int unsigned MAX_WORDS = (`HARNESS_ROM_WORDS > `HARNESS_RAM_WORDS) ?
                                      `HARNESS_ROM_WORDS : `HARNESS_RAM_WORDS;
  localparam int unsigned IDX_W     = $clog2(MAX_WORDS);

  typedef logic [IDX_W-1:0] word_idx_t;

  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,
    REGION_ROM  = 2'd1,
    REGION_RAM  = 2'd2,
    REGION_EXIT = 2'd3
  } region_e;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam addr_t ROM_BASE  = 16'h0000;
  localparam addr_t ROM_LEN   = addr_t'(`HARNESS_ROM_WORDS * `HARNESS_BE_W);
  localparam addr_t RAM_BASE  = 16'h1000;
  localparam addr_t RAM_LEN   = addr_t'(`HARNESS_RAM_WORDS * `HARNESS_BE_W);
  localparam addr_t EXIT_ADDR = 16'h2000;

endpackage

//--- rtl/harness_dec_if.sv
`timescale 1ns/1ps
`include "harness_params.svh"

interface harness_dec_if;
  import harness_map_pkg::*;

  logic                       valid;
  logic                       ready;
  region_e                    region;
  word_idx_t                  word_idx;
  logic                       we;
  logic [`HARNESS_BE_W-1:0]   be;
  logic [`HARNESS_DATA_W-1:0] wdata;
  // Unmapped or misaligned
  logic                       dec_err;

  modport dec (
    output valid, region, word_idx, we, be, wdata, dec_err,
    input  ready
  );

  modport bank (
    input  valid, region, word_idx, we, be, wdata, dec_err,
    output ready
  );

endinterface

//--- rtl/harness_slice.sv
`timescale 1ns/1ps

module harness_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     out_valid_q;
  logic     skid_valid_q;
  payload_t out_data_q;
  payload_t skid_data_q;
  logic     out_free;

  // Output slot empty or drained this cycle
  assign out_free    = ~out_valid_q | out_ready_i;
  // Registered ready, so no combinational path from out_ready_i
  assign in_ready_o  = ~skid_valid_q;
  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      out_valid_q  <= skid_valid_q | in_valid_i;
      skid_valid_q <= 1'b0;
    end else if (in_valid_i && !skid_valid_q) begin
      // Output stalled, park the new beat
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      if (skid_valid_q) begin
        out_data_q <= skid_data_q;
      end else if (in_valid_i) begin
        out_data_q <= in_data_i;
      end
    end else if (in_valid_i && !skid_valid_q) begin
      skid_data_q <= in_data_i;
    end
  end

endmodule

//--- rtl/harness_addr_decode.sv
`timescale 1ns/1ps
`include "harness_params.svh"

module harness_addr_decode (
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  harness_bus_pkg::bus_req_t req_i,
  harness_dec_if.dec                dec_o
);
  import harness_map_pkg::*;

  localparam int unsigned OFFS_W = $clog2(`HARNESS_BE_W);

  addr_t   rom_offs;
  addr_t   ram_offs;
  region_e region;
  addr_t   offs;
  logic    misaligned;

  // Offsets wrap below the base, so one compare covers both bounds
  assign rom_offs   = req_i.addr - ROM_BASE;
  assign ram_offs   = req_i.addr - RAM_BASE;
  assign misaligned = |req_i.addr[OFFS_W-1:0];

  always_comb begin
    region = REGION_NONE;
    offs   = '0;
    if (rom_offs < ROM_LEN) begin
      region = REGION_ROM;
      offs   = rom_offs;
    end else if (ram_offs < RAM_LEN) begin
      region = REGION_RAM;
      offs   = ram_offs;
    end else if (req_i.addr == EXIT_ADDR) begin
      region = REGION_EXIT;
    end
  end

  // Handshake passes straight through
  assign dec_o.valid    = req_valid_i;
  assign req_ready_o    = dec_o.ready;

  assign dec_o.region   = region;
  assign dec_o.word_idx = offs[OFFS_W +: IDX_W];
  assign dec_o.we       = req_i.we;
  assign dec_o.be       = req_i.be;
  assign dec_o.wdata    = req_i.wdata;
  assign dec_o.dec_err  = (region == REGION_NONE) | misaligned;

endmodule

//--- rtl/harness_mem_bank.sv
`timescale 1ns/1ps
`include "harness_params.svh"

module harness_mem_bank (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  harness_dec_if.bank                dec_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output harness_bus_pkg::bus_resp_t resp_o,
  output logic [`HARNESS_DATA_W-1:0] exit_o
);
  import harness_bus_pkg::*;
  import harness_map_pkg::*;

  localparam int unsigned DATA_W = `HARNESS_DATA_W;
  localparam int unsigned BE_W   = `HARNESS_BE_W;
  localparam int unsigned HALF_W = DATA_W / 2;

  logic [DATA_W-1:0] ram_q [`HARNESS_RAM_WORDS];
  logic [DATA_W-1:0] exit_q;
  logic              resp_valid_q;
  bus_resp_t         resp_d;
  bus_resp_t         resp_q;
  logic              accept;
  logic              ram_wr;
  logic              exit_wr;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // Boot ROM word is the tag joined to its own index
  function automatic logic [DATA_W-1:0] rom_word(input word_idx_t idx);
    return {`HARNESS_ROM_TAG, HALF_W'(idx)};
  endfunction

  // --------------------------------------------------------------------------
  // Request acceptance and response forming
  // --------------------------------------------------------------------------
  assign dec_i.ready = ~resp_valid_q | resp_ready_i;
  assign accept      = dec_i.valid & dec_i.ready;
  assign ram_wr  = accept & ~dec_i.dec_err & dec_i.we & (dec_i.region == REGION_RAM);
  assign exit_wr = accept & ~dec_i.dec_err & dec_i.we & (dec_i.region == REGION_EXIT);

  always_comb begin
    resp_d.rdata  = '0;
    resp_d.status = RESP_OKAY;
    if (dec_i.dec_err) begin
      resp_d.status = RESP_ERROR;
    end else begin
      case (dec_i.region)
        REGION_ROM: begin
          if (dec_i.we) begin
            resp_d.status = RESP_ERROR;
          end else begin
            resp_d.rdata = rom_word(dec_i.word_idx);
          end
        end
        REGION_RAM: begin
          if (!dec_i.we) resp_d.rdata = ram_q[dec_i.word_idx];
        end
        REGION_EXIT: begin
          if (!dec_i.we) resp_d.rdata = exit_q;
        end
        default: resp_d.status = RESP_ERROR;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      exit_q       <= '0;
    end else begin
      if (dec_i.ready) resp_valid_q <= dec_i.valid;
      if (exit_wr) exit_q <= be_merge(exit_q, dec_i.wdata, dec_i.be);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) resp_q <= resp_d;
    if (ram_wr) begin
      ram_q[dec_i.word_idx] <= be_merge(ram_q[dec_i.word_idx], dec_i.wdata, dec_i.be);
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;
  assign exit_o       = exit_q;

endmodule

//--- rtl/harness_debug_gate.sv
`timescale 1ns/1ps
`include "harness_params.svh"

module harness_debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_W = $clog2(`HARNESS_DBG_DELAY + 1);

  logic [CNT_W-1:0] cnt_q;

  // Gives the boot code time to run before a debug request can land
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CNT_W'(`HARNESS_DBG_DELAY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  assign debug_req_o = (cnt_q == '0) & debug_req_i;

endmodule

//--- rtl/harness_top.sv
`timescale 1ns/1ps
`include "harness_params.svh"

module harness_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Request channel
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [`HARNESS_ADDR_W-1:0] req_addr_i,
  input  logic                       req_we_i,
  input  logic [`HARNESS_BE_W-1:0]   req_be_i,
  input  logic [`HARNESS_DATA_W-1:0] req_wdata_i,
  // Response channel
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output logic [`HARNESS_DATA_W-1:0] resp_rdata_o,
  output logic                       resp_err_o,
  // Debug and exit code
  input  logic                       debug_req_i,
  output logic                       debug_req_o,
  output logic [`HARNESS_DATA_W-1:0] exit_o
);
  import harness_bus_pkg::*;

  bus_req_t  req_in;
  bus_req_t  req_sl;
  logic      req_sl_valid;
  logic      req_sl_ready;
  bus_resp_t resp_bank;
  logic      resp_bank_valid;
  logic      resp_bank_ready;
  bus_resp_t resp_out;

  assign req_in.addr  = req_addr_i;
  assign req_in.we    = req_we_i;
  assign req_in.be    = req_be_i;
  assign req_in.wdata = req_wdata_i;

  // --------------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------------
  harness_slice #(
    .payload_t ( bus_req_t )
  ) u_req_slice (
    .clk_i       ( clk_i        ),
    .rst_ni      ( rst_ni       ),
    .in_valid_i  ( req_valid_i  ),
    .in_ready_o  ( req_ready_o  ),
    .in_data_i   ( req_in       ),
    .out_valid_o ( req_sl_valid ),
    .out_ready_i ( req_sl_ready ),
    .out_data_o  ( req_sl       )
  );

  harness_dec_if u_dec_if ();

  harness_addr_decode u_addr_decode (
    .req_valid_i ( req_sl_valid ),
    .req_ready_o ( req_sl_ready ),
    .req_i       ( req_sl       ),
    .dec_o       ( u_dec_if     )
  );

  harness_mem_bank u_mem_bank (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .dec_i        ( u_dec_if        ),
    .resp_valid_o ( resp_bank_valid ),
    .resp_ready_i ( resp_bank_ready ),
    .resp_o       ( resp_bank       ),
    .exit_o       ( exit_o          )
  );

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------
  harness_slice #(
    .payload_t ( bus_resp_t )
  ) u_resp_slice (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .in_valid_i  ( resp_bank_valid ),
    .in_ready_o  ( resp_bank_ready ),
    .in_data_i   ( resp_bank       ),
    .out_valid_o ( resp_valid_o    ),
    .out_ready_i ( resp_ready_i    ),
    .out_data_o  ( resp_out        )
  );

  assign resp_rdata_o = resp_out.rdata;
  assign resp_err_o   = (resp_out.status == RESP_ERROR);

  harness_debug_gate u_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- tb/harness_properties.sv
`timescale 1ns/1ps
`include "harness_params.svh"

module harness_properties (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       req_valid_i,
  input logic                       req_ready_o,
  input logic [`HARNESS_ADDR_W-1:0] req_addr_i,
  input logic                       req_we_i,
  input logic [`HARNESS_BE_W-1:0]   req_be_i,
  input logic [`HARNESS_DATA_W-1:0] req_wdata_i,
  input logic                       resp_valid_o,
  input logic                       resp_ready_i,
  input logic [`HARNESS_DATA_W-1:0] resp_rdata_o,
  input logic                       resp_err_o
);

  // Stalled request keeps valid and payload
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_o |=>
      req_valid_i && $stable({req_addr_i, req_we_i, req_be_i, req_wdata_i}))
    else $error("request dropped or changed while stalled");

  // Stalled response keeps valid and payload
  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable({resp_rdata_o, resp_err_o}))
    else $error("response dropped or changed while stalled");

  resp_reset_a: assert property (@(posedge clk_i) !rst_ni |=> !resp_valid_o)
    else $error("response valid high right after reset");

endmodule

bind harness_top harness_properties u_harness_properties (.*);

//--- tb/tb_harness.sv
`timescale 1ns/1ps
`include "harness_params.svh"

module tb_harness;

  localparam int NUM_TESTS = 18;
  // First table entry that runs under random back-pressure
  localparam int BP_FIRST  = 13;
  localparam int TIMEOUT   = 40 * NUM_TESTS + 200;
  localparam int DBG_EDGES = `HARNESS_DBG_DELAY + 5;
  localparam logic [`HARNESS_DATA_W-1:0] EXIT_CODE = 32'hCAFE_0042;

  typedef struct packed {
    int idx;
    int cyc;
  } pend_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       req_valid_i;
  logic                       req_ready_o;
  logic [`HARNESS_ADDR_W-1:0] req_addr_i;
  logic                       req_we_i;
  logic [`HARNESS_BE_W-1:0]   req_be_i;
  logic [`HARNESS_DATA_W-1:0] req_wdata_i;
  logic                       resp_valid_o;
  logic                       resp_ready_i;
  logic [`HARNESS_DATA_W-1:0] resp_rdata_o;
  logic                       resp_err_o;
  logic                       debug_req_i;
  logic                       debug_req_o;
  logic [`HARNESS_DATA_W-1:0] exit_o;

  // Stimulus and expected values, one entry per test
  string                      t_name  [NUM_TESTS];
  logic                       t_we    [NUM_TESTS];
  logic [`HARNESS_ADDR_W-1:0] t_addr  [NUM_TESTS];
  logic [`HARNESS_BE_W-1:0]   t_be    [NUM_TESTS];
  logic [`HARNESS_DATA_W-1:0] t_wdata [NUM_TESTS];
  logic [`HARNESS_DATA_W-1:0] t_rdata [NUM_TESTS];
  logic                       t_err   [NUM_TESTS];
  int                         n_tests;

  pend_t       pend_q [$];
  int          cycle;
  int          resp_count;
  int          drv_fail;
  int          mon_fail;
  int          dbg_fail;
  logic        dbg_done;
  logic        bp_mode;
  logic [31:0] rnd_state;

  harness_top u_harness_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_test(input string name, input logic we,
                          input logic [`HARNESS_ADDR_W-1:0] addr,
                          input logic [`HARNESS_BE_W-1:0] be,
                          input logic [`HARNESS_DATA_W-1:0] wdata,
                          input logic [`HARNESS_DATA_W-1:0] rdata, input logic err);
    t_name[n_tests]  = name;
    t_we[n_tests]    = we;
    t_addr[n_tests]  = addr;
    t_be[n_tests]    = be;
    t_wdata[n_tests] = wdata;
    t_rdata[n_tests] = rdata;
    t_err[n_tests]   = err;
    n_tests++;
  endtask

  task automatic check_value(input string test, input string what, input logic [31:0] exp,
                             input logic [31:0] act, inout logic bad);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h, got %h", test, what, exp, act);
      bad = 1'b1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Cycle count, response ready and timeout
  // --------------------------------------------------------------------------
  initial begin : ready_drive
    cycle        = 0;
    rnd_state    = 32'd70;
    resp_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      cycle        <= cycle + 1;
      rnd_state    <= xorshift32(rnd_state);
      resp_ready_i <= bp_mode ? rnd_state[0] : 1'b1;
    end
  end

  initial begin : watchdog
    @(posedge clk_i);
    while (cycle < TIMEOUT) @(posedge clk_i);
    $display("Timeout after %0d cycles with responses still missing", cycle);
    $display("TB FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // In-order response checks
  // --------------------------------------------------------------------------
  initial begin : resp_check
    pend_t p;
    logic  bad;
    resp_count = 0;
    mon_fail   = 0;
    forever begin
      @(posedge clk_i);
      if (resp_valid_o && resp_ready_i) begin
        if (pend_q.size() == 0) begin
          $display("A response arrived with no request outstanding");
          mon_fail++;
        end else begin
          p   = pend_q.pop_front();
          bad = 1'b0;
          check_value(t_name[p.idx], "rdata", t_rdata[p.idx], resp_rdata_o, bad);
          check_value(t_name[p.idx], "err", 32'(t_err[p.idx]), 32'(resp_err_o), bad);
          // Fixed latency only holds with ready high
          if (p.idx < BP_FIRST) begin
            check_value(t_name[p.idx], "latency", 32'd3, 32'(cycle - p.cyc), bad);
          end
          if (bad) mon_fail++;
          $display("%-18s %s", t_name[p.idx], bad ? "fail" : "pass");
          resp_count <= resp_count + 1;
        end
      end
    end
  end

  initial begin : debug_check
    int   k;
    logic bad;
    logic exp;
    debug_req_i = 1'b1;
    k           = 0;
    bad         = 1'b0;
    dbg_fail    = 0;
    dbg_done    = 1'b0;
    while (k < DBG_EDGES) begin
      @(posedge clk_i);
      if (rst_ni) begin
        k++;
        exp = (k > `HARNESS_DBG_DELAY);
        check_value($sformatf("debug_gate edge %0d", k), "debug_req_o", 32'(exp),
                    32'(debug_req_o), bad);
      end
    end
    // Open gate follows the input
    debug_req_i <= 1'b0;
    @(posedge clk_i);
    check_value("debug_gate follow", "debug_req_o", 32'd0, 32'(debug_req_o), bad);
    debug_req_i <= 1'b1;
    @(posedge clk_i);
    check_value("debug_gate follow", "debug_req_o", 32'd1, 32'(debug_req_o), bad);
    if (bad) dbg_fail++;
    $display("%-18s %s", "debug_gate", bad ? "fail" : "pass");
    dbg_done = 1'b1;
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : drive
    logic bad;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_we_i    = 1'b0;
    req_be_i    = '0;
    req_wdata_i = '0;
    bp_mode     = 1'b0;
    drv_fail    = 0;
    n_tests     = 0;

    add_test("ram_full_wr",     1'b1, 16'h1004, 4'hF, 32'h1234_5678, 32'h0,         1'b0);
    add_test("ram_full_rd",     1'b0, 16'h1004, 4'hF, 32'h0,         32'h1234_5678, 1'b0);
    add_test("ram_part_wr",     1'b1, 16'h1004, 4'h5, 32'hAABB_CCDD, 32'h0,         1'b0);
    add_test("ram_part_rd",     1'b0, 16'h1004, 4'hF, 32'h0,         32'h12BB_56DD, 1'b0);
    add_test("rom_first_rd",    1'b0, 16'h0000, 4'hF, 32'h0, {`HARNESS_ROM_TAG, 16'h0000}, 1'b0);
    add_test("rom_last_rd",     1'b0, 16'h03FC, 4'hF, 32'h0, {`HARNESS_ROM_TAG, 16'h00FF}, 1'b0);
    add_test("rom_wr",          1'b1, 16'h0010, 4'hF, 32'hDEAD_BEEF, 32'h0,         1'b1);
    add_test("rom_rd_after_wr", 1'b0, 16'h0010, 4'hF, 32'h0, {`HARNESS_ROM_TAG, 16'h0004}, 1'b0);
    add_test("unmapped_rd",     1'b0, 16'h0800, 4'hF, 32'h0,         32'h0,         1'b1);
    add_test("unmapped_wr",     1'b1, 16'h3000, 4'hF, 32'h1,         32'h0,         1'b1);
    add_test("misaligned_rd",   1'b0, 16'h1002, 4'hF, 32'h0,         32'h0,         1'b1);
    add_test("exit_wr",         1'b1, 16'h2000, 4'hF, EXIT_CODE,     32'h0,         1'b0);
    add_test("exit_rd",         1'b0, 16'h2000, 4'hF, 32'h0,         EXIT_CODE,     1'b0);
    add_test("bp_ram_wr_a",     1'b1, 16'h1100, 4'hF, 32'h0BAD_0001, 32'h0,         1'b0);
    add_test("bp_ram_wr_b",     1'b1, 16'h13FC, 4'hF, 32'h0BAD_0002, 32'h0,         1'b0);
    add_test("bp_ram_rd_a",     1'b0, 16'h1100, 4'hF, 32'h0,         32'h0BAD_0001, 1'b0);
    add_test("bp_ram_rd_b",     1'b0, 16'h13FC, 4'hF, 32'h0,         32'h0BAD_0002, 1'b0);
    add_test("bp_rom_rd",       1'b0, 16'h0020, 4'hF, 32'h0, {`HARNESS_ROM_TAG, 16'h0008}, 1'b0);

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    bad = 1'b0;
    check_value("reset_state", "resp_valid_o", 32'd0, 32'(resp_valid_o), bad);
    check_value("reset_state", "req_ready_o", 32'd1, 32'(req_ready_o), bad);
    check_value("reset_state", "exit_o", 32'd0, exit_o, bad);
    if (bad) drv_fail++;
    $display("%-18s %s", "reset_state", bad ? "fail" : "pass");

    for (int i = 0; i < NUM_TESTS; i++) begin
      if (i == BP_FIRST) begin
        // Drain the pipeline before random back-pressure starts
        req_valid_i <= 1'b0;
        while (resp_count != BP_FIRST) @(posedge clk_i);
        bad = 1'b0;
        check_value("exit_code", "exit_o", EXIT_CODE, exit_o, bad);
        if (bad) drv_fail++;
        $display("%-18s %s", "exit_code", bad ? "fail" : "pass");
        bp_mode <= 1'b1;
      end
      req_valid_i <= 1'b1;
      req_addr_i  <= t_addr[i];
      req_we_i    <= t_we[i];
      req_be_i    <= t_be[i];
      req_wdata_i <= t_wdata[i];
      @(posedge clk_i);
      while (!req_ready_o) @(posedge clk_i);
      pend_q.push_back('{idx: i, cyc: cycle});
    end
    req_valid_i <= 1'b0;
    while (resp_count != NUM_TESTS) @(posedge clk_i);
    wait (dbg_done);

    $display("%0d tests, %0d failed", NUM_TESTS + 3, drv_fail + mon_fail + dbg_fail);
    if (drv_fail + mon_fail + dbg_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+rtl
rtl/harness_bus_pkg.sv
rtl/harness_map_pkg.sv
rtl/harness_dec_if.sv
rtl/harness_slice.sv
rtl/harness_addr_decode.sv
rtl/harness_mem_bank.sv
rtl/harness_debug_gate.sv
rtl/harness_top.sv
tb/harness_properties.sv
tb/tb_harness.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_harness &&
  ./obj_dir/Vtb_harness > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
